//--- xgmii_pkg.sv
// XGMII types, character codes, fixed control words, buffer sizing and the buffered word
`default_nettype none

package xgmii_pkg;

    // Lane geometry, lane 0 is the low byte
    localparam int LANES      = 8;
    localparam int LANE_IDX_W = 3;
    localparam int DATA_W     = 64;

    typedef logic [DATA_W-1:0] xgmii_data_t;
    typedef logic [LANES-1:0]  xgmii_ctrl_t;

    // Control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // Preamble and start frame delimiter
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // Start in lane 0, six preamble bytes, SFD in lane 7
    localparam xgmii_data_t XGMII_START_WORD = {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START};
    localparam xgmii_ctrl_t XGMII_START_CTRL = 8'h01;

    localparam xgmii_data_t XGMII_IDLE_WORD = {LANES{XGMII_IDLE}};

    // Terminate in lane 0, used after a full last word
    localparam xgmii_data_t XGMII_TERM_WORD = {{(LANES - 1){XGMII_IDLE}}, XGMII_TERM};

    // Frame buffer sizing, in payload words
    localparam int FIFO_DEPTH  = 64;
    localparam int FIFO_ADDR_W = 6;

    // Width of the frame counters
    localparam int COUNT_W = 16;

    // One stored payload word
    // keep is contiguous from lane 0, only the last word may be partial
    typedef struct packed {
        xgmii_data_t       data;
        logic [LANES-1:0]  keep;
        logic              last;
    } frame_word_t;

endpackage

`default_nettype wire

//--- frame_if.sv
// Interfaces frame_wr_if and frame_rd_if with their modports
`default_nettype none
`timescale 1ns/10ps

// Deframer to buffer, one strobe per word
interface frame_wr_if;
    import xgmii_pkg::*;

    frame_word_t word;
    logic        wr;
    // Aborts the frame under construction
    logic        bad;

    modport deframer (
        output word,
        output wr,
        output bad
    );

    modport buffer (
        input word,
        input wr,
        input bad
    );
endinterface

// Buffer to framer, head word shown combinationally
interface frame_rd_if;
    import xgmii_pkg::*;

    frame_word_t word;
    logic        frame_avail;
    logic        rd;

    modport buffer (
        output word,
        output frame_avail,
        input  rd
    );

    modport framer (
        input  word,
        input  frame_avail,
        output rd
    );
endinterface

`default_nettype wire

//--- xgmii_rx_deframer.sv
// Module xgmii_rx_deframer, XGMII receive words to payload words with keep, last and bad
`default_nettype none
`timescale 1ns/10ps

module xgmii_rx_deframer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  xgmii_pkg::xgmii_data_t rxd,
    input  xgmii_pkg::xgmii_ctrl_t rxc,
    input  logic                   block_lock,
    frame_wr_if.deframer           out
);
    import xgmii_pkg::*;

    // Input register stage
    xgmii_data_t rxd_q;
    xgmii_ctrl_t rxc_q;
    logic        lock_q;

    logic        in_frame;
    logic        hold_valid;
    frame_word_t hold_word;

    // Decode of the registered word
    logic                  is_start;
    logic                  is_data;
    logic                  has_error;
    logic                  term_found;
    logic                  term_ok;
    logic [LANE_IDX_W-1:0] term_lane;
    xgmii_ctrl_t           term_keep;

    logic emit;
    logic emit_last;
    logic abort;
    logic load_hold;
    logic in_frame_n;
    logic hold_valid_n;

    assign is_start = (rxc_q == XGMII_START_CTRL) && (rxd_q == XGMII_START_WORD);
    assign is_data  = (rxc_q == '0);

    // Lowest terminate lane wins
    always_comb begin
        has_error  = 1'b0;
        term_found = 1'b0;
        term_lane  = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (rxc_q[i] && rxd_q[8*i +: 8] == XGMII_ERROR) begin
                has_error = 1'b1;
            end
            if (rxc_q[i] && rxd_q[8*i +: 8] == XGMII_TERM) begin
                term_found = 1'b1;
                term_lane  = LANE_IDX_W'(i);
            end
        end
        for (int i = 0; i < LANES; i++) begin
            term_keep[i] = (i < int'(term_lane));
        end
    end

    // Data lanes ahead of the terminate must be plain data
    assign term_ok = term_found && ((rxc_q & term_keep) == '0) && !has_error;

    always_comb begin
        emit         = 1'b0;
        emit_last    = 1'b0;
        abort        = 1'b0;
        load_hold    = 1'b0;
        in_frame_n   = in_frame;
        hold_valid_n = hold_valid;

        // Terminate seen last cycle, flush the partial word
        if (hold_valid && hold_word.last) begin
            emit         = 1'b1;
            emit_last    = 1'b1;
            hold_valid_n = 1'b0;
        end

        if (!in_frame) begin
            in_frame_n = is_start && lock_q;
        end else if (!lock_q || !(is_data || term_ok)) begin
            // Lock loss, error or stray control, a new start restarts
            abort        = 1'b1;
            hold_valid_n = 1'b0;
            in_frame_n   = is_start && lock_q;
        end else if (is_data || term_lane != '0) begin
            emit         = hold_valid;
            load_hold    = 1'b1;
            hold_valid_n = 1'b1;
            in_frame_n   = is_data;
        end else begin
            // Terminate in lane 0 closes the held word
            emit         = hold_valid;
            emit_last    = 1'b1;
            abort        = !hold_valid;
            hold_valid_n = 1'b0;
            in_frame_n   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_q     <= 1'b0;
            in_frame   <= 1'b0;
            hold_valid <= 1'b0;
            out.wr     <= 1'b0;
            out.bad    <= 1'b0;
        end else begin
            lock_q     <= block_lock;
            in_frame   <= in_frame_n;
            hold_valid <= hold_valid_n;
            out.wr     <= emit;
            out.bad    <= abort;
        end
    end

    always_ff @(posedge clk) begin
        rxd_q <= rxd;
        rxc_q <= rxc;
        if (load_hold) begin
            hold_word <= '{data: rxd_q, keep: is_data ? {LANES{1'b1}} : term_keep,
                           last: !is_data};
        end
        out.word <= '{data: hold_word.data, keep: hold_word.keep, last: emit_last};
    end

endmodule

`default_nettype wire

//--- frame_fifo.sv
// Module frame_fifo, frame buffer with commit on last and rollback on bad or overflow
`default_nettype none
`timescale 1ns/10ps

module frame_fifo (
    input  logic       clk,
    input  logic       rst_n,
    frame_wr_if.buffer wr_port,
    frame_rd_if.buffer rd_port,
    output logic       committed,
    output logic       dropped
);
    import xgmii_pkg::*;

    // Extra top bit tells full from empty
    typedef logic [FIFO_ADDR_W:0] ptr_t;

    frame_word_t mem [FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t commit_ptr;
    ptr_t rd_ptr;

    // Committed frames still in the buffer
    logic [FIFO_ADDR_W:0] frame_cnt;

    // Rest of a rolled back frame is ignored
    logic discard;

    logic full;
    logic frame_end;
    logic accept;
    logic commit;
    logic drop;
    logic read_last;

    assign full = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                  (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    assign frame_end = wr_port.bad || (wr_port.wr && wr_port.word.last);
    assign accept    = wr_port.wr && !wr_port.bad && !discard && !full;
    assign commit    = accept && wr_port.word.last;

    // Bad frame, or a word that finds no room
    assign drop      = !discard && (wr_port.bad || (wr_port.wr && full));
    assign read_last = rd_port.rd && rd_port.word.last;

    assign committed = commit;
    assign dropped   = drop;

    // Head word for the framer
    assign rd_port.word        = mem[rd_ptr[FIFO_ADDR_W-1:0]];
    assign rd_port.frame_avail = (frame_cnt != '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wr_port.word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            frame_cnt  <= '0;
            discard    <= 1'b0;
        end else begin
            // Rollback to the last frame boundary
            if (drop) begin
                wr_ptr <= commit_ptr;
            end else if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (commit) begin
                commit_ptr <= wr_ptr + 1'b1;
            end

            if (rd_port.rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (frame_end) begin
                discard <= 1'b0;
            end else if (drop) begin
                discard <= 1'b1;
            end

            case ({commit, read_last})
                2'b10: frame_cnt <= frame_cnt + 1'b1;
                2'b01: frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- xgmii_tx_framer.sv
// Module xgmii_tx_framer, buffered frames to XGMII transmit words
`default_nettype none
`timescale 1ns/10ps

module xgmii_tx_framer (
    input  logic                   clk,
    input  logic                   rst_n,
    frame_rd_if.framer             in,
    output xgmii_pkg::xgmii_data_t txd,
    output xgmii_pkg::xgmii_ctrl_t txc
);
    import xgmii_pkg::*;

    // Each state names the word registered in it
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_TERM,
        ST_IFG
    } state_t;

    state_t      state;
    state_t      state_n;
    xgmii_data_t txd_n;
    xgmii_ctrl_t txc_n;
    logic        term_done;

    always_comb begin
        state_n   = state;
        txd_n     = XGMII_IDLE_WORD;
        txc_n     = '1;
        in.rd     = 1'b0;
        term_done = 1'b0;

        case (state)
            ST_IDLE: begin
                if (in.frame_avail) begin
                    state_n = ST_START;
                end
            end

            ST_START: begin
                txd_n   = XGMII_START_WORD;
                txc_n   = XGMII_START_CTRL;
                state_n = ST_DATA;
            end

            ST_DATA: begin
                in.rd = 1'b1;
                // Terminate goes in the first lane past keep, idle after it
                for (int i = 0; i < LANES; i++) begin
                    if (in.word.keep[i]) begin
                        txd_n[8*i +: 8] = in.word.data[8*i +: 8];
                        txc_n[i]        = 1'b0;
                    end else if (!term_done && in.word.last) begin
                        txd_n[8*i +: 8] = XGMII_TERM;
                        term_done       = 1'b1;
                    end
                end
                if (in.word.last) begin
                    // A full last word needs its own terminate word
                    state_n = (&in.word.keep) ? ST_TERM : ST_IFG;
                end
            end

            ST_TERM: begin
                txd_n   = XGMII_TERM_WORD;
                state_n = ST_IFG;
            end

            ST_IFG: begin
                // One idle word already sent
                state_n = in.frame_avail ? ST_START : ST_IDLE;
            end

            default: begin
                state_n = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            txd   <= XGMII_IDLE_WORD;
            txc   <= '1;
        end else begin
            state <= state_n;
            txd   <= txd_n;
            txc   <= txc_n;
        end
    end

endmodule

`default_nettype wire

//--- xgmii_loopback_core.sv
// Module xgmii_loopback_core, XGMII loopback top level with frame counters
`default_nettype none
`timescale 1ns/10ps

module xgmii_loopback_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  xgmii_pkg::xgmii_data_t        rxd,
    input  xgmii_pkg::xgmii_ctrl_t        rxc,
    input  logic                          block_lock,
    output xgmii_pkg::xgmii_data_t        txd,
    output xgmii_pkg::xgmii_ctrl_t        txc,
    output logic [xgmii_pkg::COUNT_W-1:0] forwarded_count,
    output logic [xgmii_pkg::COUNT_W-1:0] dropped_count
);

    frame_wr_if wr_bus ();
    frame_rd_if rd_bus ();

    logic committed;
    logic dropped;

    xgmii_rx_deframer u_deframer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .rxc        (rxc),
        .block_lock (block_lock),
        .out        (wr_bus.deframer)
    );

    frame_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_port   (wr_bus.buffer),
        .rd_port   (rd_bus.buffer),
        .committed (committed),
        .dropped   (dropped)
    );

    xgmii_tx_framer u_framer (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (rd_bus.framer),
        .txd   (txd),
        .txc   (txc)
    );

    // Saturating frame counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            forwarded_count <= '0;
            dropped_count   <= '0;
        end else begin
            if (committed && forwarded_count != '1) begin
                forwarded_count <= forwarded_count + 1'b1;
            end
            if (dropped && dropped_count != '1) begin
                dropped_count <= dropped_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- frame_fifo_properties.sv
// Module frame_fifo_properties, concurrent assertions on the frame buffer, and its bind
`default_nettype none
`timescale 1ns/10ps

module frame_fifo_properties (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          wr,
    input logic                          rd,
    input logic                          full,
    input logic [xgmii_pkg::FIFO_ADDR_W:0] wr_ptr,
    input logic [xgmii_pkg::FIFO_ADDR_W:0] rd_ptr,
    input logic                          frame_avail,
    input logic                          committed,
    input logic                          dropped
);

    logic empty;

    // Number of assertion failures
    int fail_count = 0;

    assign empty = (wr_ptr == rd_ptr);

    a_no_access_at_limit: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && rd && (full || empty)))
        else begin
            $error("write and read together at a buffer limit");
            fail_count++;
        end

    // Avail follows a commit by one cycle
    a_avail_after_commit: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(frame_avail) |-> $past(committed))
        else begin
            $error("frame_avail rose without a committed frame");
            fail_count++;
        end

    a_commit_drop_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(committed && dropped))
        else begin
            $error("committed and dropped in the same cycle");
            fail_count++;
        end

    a_read_needs_frame: assert property (@(posedge clk) disable iff (!rst_n)
        rd |-> frame_avail)
        else begin
            $error("read with no committed frame");
            fail_count++;
        end

endmodule

bind frame_fifo frame_fifo_properties u_fifo_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr          (wr_port.wr),
    .rd          (rd_port.rd),
    .full        (full),
    .wr_ptr      (wr_ptr),
    .rd_ptr      (rd_ptr),
    .frame_avail (rd_port.frame_avail),
    .committed   (committed),
    .dropped     (dropped)
);

`default_nettype wire

//--- tb_xgmii_loopback.sv
// Testbench tb_xgmii_loopback, trace driven XGMII frames with a transmit monitor and checks
`default_nettype none
`timescale 1ns/10ps

module tb_xgmii_loopback;
    import xgmii_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    // Start in lane 0, six preamble bytes, SFD in lane 7
    localparam xgmii_data_t START_WORD = {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START};
    localparam xgmii_data_t IDLE_WORD  = {8{XGMII_IDLE}};

    logic               clk;
    logic               rst_n;
    xgmii_data_t        rxd;
    xgmii_ctrl_t        rxc;
    logic               block_lock;
    xgmii_data_t        txd;
    xgmii_ctrl_t        txc;
    logic [COUNT_W-1:0] forwarded_count;
    logic [COUNT_W-1:0] dropped_count;

    // Words still to come out on txd, oldest first
    frame_word_t exp_q[$];
    logic [7:0]  frame_bytes[$];

    integer seed;
    int     good_frames;
    int     bad_frames;

    // Monitor state
    logic        tx_in_frame;
    logic        tx_idle_seen;
    logic        tx_pend_valid;
    frame_word_t tx_pend;
    int          tx_frames;
    int          tx_words;

    xgmii_loopback_core u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .rxd             (rxd),
        .rxc             (rxc),
        .block_lock      (block_lock),
        .txd             (txd),
        .txc             (txc),
        .forwarded_count (forwarded_count),
        .dropped_count   (dropped_count)
    );

    always #50 clk = ~clk;

    task automatic stop_run(string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic report_mismatch(string name, string exp_s, string act_s);
        stop_run($sformatf("FAILED %s expected %s actual %s", name, exp_s, act_s));
    endtask

    task automatic check_frame_word(string name, frame_word_t exp, frame_word_t act);
        if (act !== exp) begin
            report_mismatch(name,
                $sformatf("data=%h keep=%b last=%b", exp.data, exp.keep, exp.last),
                $sformatf("data=%h keep=%b last=%b", act.data, act.keep, act.last));
        end
    endtask

    task automatic check_count(string name, logic [COUNT_W-1:0] exp, logic [COUNT_W-1:0] act);
        if (act !== exp) begin
            report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
        end
    endtask

    // Lanes flagged in exp must carry idle
    task automatic check_idle(string name, xgmii_ctrl_t exp, xgmii_ctrl_t act, xgmii_data_t data);
        xgmii_data_t exp_data;
        exp_data = data;
        for (int i = 0; i < 8; i++) begin
            if (exp[i]) begin
                exp_data[8*i +: 8] = XGMII_IDLE;
            end
        end
        if (act !== exp || data !== exp_data) begin
            report_mismatch(name, $sformatf("txc=%b txd=%h", exp, exp_data),
                            $sformatf("txc=%b txd=%h", act, data));
        end
    endtask

    // Bound buffer assertions count their failures
    task automatic check_buffer_assertions();
        if (u_dut.u_fifo.u_fifo_props.fail_count != 0) begin
            stop_run("an assertion on the frame buffer failed");
        end
    endtask

    // Payload word with unused lanes zeroed
    function automatic frame_word_t make_word(xgmii_data_t data, int nbytes, logic last);
        frame_word_t w;
        w.data = '0;
        w.keep = '0;
        w.last = last;
        for (int i = 0; i < nbytes; i++) begin
            w.data[8*i +: 8] = data[8*i +: 8];
            w.keep[i]        = 1'b1;
        end
        return w;
    endfunction

    task automatic push_expected(int len);
        xgmii_data_t d;
        int          nbytes;
        for (int w = 0; w <= (len - 1) / 8; w++) begin
            d      = '0;
            nbytes = (len - 8 * w > 8) ? 8 : len - 8 * w;
            for (int i = 0; i < nbytes; i++) begin
                d[8*i +: 8] = frame_bytes[8 * w + i];
            end
            exp_q.push_back(make_word(d, nbytes, w == (len - 1) / 8));
        end
    endtask

    task automatic drive_word(xgmii_data_t d, xgmii_ctrl_t c, logic lock);
        @(posedge clk);
        #5;
        rxd        = d;
        rxc        = c;
        block_lock = lock;
    endtask

    task automatic send_frame(logic [7:0] kind, int len, int gap, int pos);
        xgmii_data_t d;
        xgmii_ctrl_t c;
        int          k;
        drive_word(START_WORD, 8'h01, 1'b1);
        // Last word carries the terminate, alone when the payload fills whole words
        for (int w = 0; w <= len / 8; w++) begin
            for (int i = 0; i < 8; i++) begin
                k = 8 * w + i;
                if (k < len && kind == "E" && k == pos) begin
                    d[8*i +: 8] = XGMII_ERROR;
                    c[i]        = 1'b1;
                end else if (k < len) begin
                    d[8*i +: 8] = frame_bytes[k];
                    c[i]        = 1'b0;
                end else if (k == len) begin
                    d[8*i +: 8] = XGMII_TERM;
                    c[i]        = 1'b1;
                end else begin
                    d[8*i +: 8] = XGMII_IDLE;
                    c[i]        = 1'b1;
                end
            end
            drive_word(d, c, !(kind == "L" && w == pos / 8));
        end
        for (int g = 0; g < gap; g++) begin
            drive_word(IDLE_WORD, '1, 1'b1);
        end
    endtask

    task automatic take_word(frame_word_t act);
        string name;
        name = $sformatf("frame %0d word %0d", tx_frames, tx_words);
        if (exp_q.size() == 0) begin
            stop_run($sformatf("unexpected %s on txd", name));
        end else begin
            check_frame_word(name, exp_q.pop_front(), act);
            tx_words++;
        end
    endtask

    task automatic wait_tx_drained(string what);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || tx_in_frame) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("timeout waiting for %s", what));
            end
        end
    endtask

    // Each bad frame adds exactly one to dropped_count
    task automatic wait_dropped(int expected);
        int cycles;
        cycles = 0;
        while (dropped_count < expected) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("timeout waiting for dropped_count to count a bad frame");
            end
        end
        check_count("dropped_count after bad frame", expected[COUNT_W-1:0], dropped_count);
    endtask

    // Splits txd into payload words, a full word waits for the next to learn last
    task automatic monitor_word();
        int          k;
        xgmii_data_t d;
        k = 8;
        for (int i = 7; i >= 0; i--) begin
            if (txc[i]) begin
                k = i;
            end
        end
        if (!tx_in_frame) begin
            if (txc === 8'h01) begin
                if (txd !== START_WORD) begin
                    report_mismatch("start word", $sformatf("%h", START_WORD),
                                    $sformatf("%h", txd));
                end
                if (!tx_idle_seen) begin
                    stop_run("start word with no idle word after the previous frame");
                end
                tx_in_frame   = 1'b1;
                tx_idle_seen  = 1'b0;
                tx_pend_valid = 1'b0;
                tx_words      = 0;
            end else begin
                check_idle("word between frames", '1, txc, txd);
                tx_idle_seen = 1'b1;
            end
        end else begin
            if (k < 8) begin
                if (txd[8*k +: 8] !== XGMII_TERM) begin
                    stop_run("control character other than terminate inside a frame");
                end
                if (k == 0 && !tx_pend_valid) begin
                    stop_run("frame with no payload on txd");
                end
                d            = txd;
                d[8*k +: 8]  = XGMII_IDLE;
                check_idle("lanes after terminate", 8'hFF << k, txc, d);
            end
            if (tx_pend_valid) begin
                tx_pend.last = (k == 0);
                take_word(tx_pend);
            end
            tx_pend_valid = 1'b0;
            if (k == 8) begin
                tx_pend       = make_word(txd, 8, 1'b0);
                tx_pend_valid = 1'b1;
            end else begin
                if (k > 0) begin
                    take_word(make_word(txd, k, 1'b1));
                end
                tx_in_frame = 1'b0;
                tx_frames++;
            end
        end
    endtask

    always @(negedge clk) begin
        check_buffer_assertions();
        if (rst_n) begin
            monitor_word();
        end
    end

    initial begin : main
        int               fd;
        int               r;
        int               len;
        int               gap;
        int               pos;
        integer           rnd;
        logic [7:0]       ch;
        logic [7:0]       b;
        logic [8*256-1:0] line_buf;

        clk           = 1'b0;
        rst_n         = 1'b0;
        rxd           = IDLE_WORD;
        rxc           = '1;
        block_lock    = 1'b1;
        seed          = 20589;
        good_frames   = 0;
        bad_frames    = 0;
        tx_in_frame   = 1'b0;
        tx_idle_seen  = 1'b0;
        tx_pend_valid = 1'b0;
        tx_pend       = '0;
        tx_frames     = 0;
        tx_words      = 0;

        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("txd after reset", '1, txc, txd);
        check_count("forwarded_count after reset", '0, forwarded_count);
        check_count("dropped_count after reset", '0, dropped_count);

        fd = $fopen("loopback_trace.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open loopback_trace.txt");
        end
        while ($fscanf(fd, " %c", ch) == 1) begin
            if (ch == "#") begin
                r = $fgets(line_buf, fd);
            end else begin
                r = $fscanf(fd, "%d %d %d", len, gap, pos);
                if (r != 3) begin
                    stop_run("trace record without length, gap and position");
                end
                frame_bytes.delete();
                for (int i = 0; i < len; i++) begin
                    if (ch == "O") begin
                        rnd = $random(seed);
                        frame_bytes.push_back(rnd[7:0]);
                    end else begin
                        r = $fscanf(fd, "%h", b);
                        frame_bytes.push_back(b);
                    end
                end
                // Long frame must find the buffer empty
                if (ch == "O") begin
                    wait_tx_drained("the buffer to empty before the long frame");
                end
                if (ch == "G") begin
                    push_expected(len);
                    good_frames++;
                end else begin
                    bad_frames++;
                end
                send_frame(ch, len, gap, pos);
                if (ch != "G") begin
                    wait_dropped(bad_frames);
                end
            end
        end
        $fclose(fd);

        wait_tx_drained("the last frames on txd");
        check_count("forwarded_count at end", good_frames[COUNT_W-1:0], forwarded_count);
        check_count("dropped_count at end", bad_frames[COUNT_W-1:0], dropped_count);
        check_buffer_assertions();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- loopback_trace.txt
# kind length gap pos, then payload bytes in hex, a record may go on over several lines
# kind G good, E error character at byte pos, L block_lock drop at byte pos, O too long (random)
G 1 3 0 a1
G 2 1 0 b1 b2
G 3 1 0 c1 c2 c3
G 4 1 0 d1 d2 d3 d4
G 5 1 0 e1 e2 e3 e4 e5
G 6 1 0 f1 f2 f3 f4 f5 f6
G 7 1 0 01 02 03 04 05 06 07
G 8 1 0 10 11 12 13 14 15 16 17
E 20 2 9 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33
G 12 2 0 40 41 42 43 44 45 46 47 48 49 4a 4b
L 24 2 13 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61 62 63 64 65 66 67
G 16 40 0 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
# long frame into an empty buffer
O 600 2 0
G 40 1 0 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93
         94 95 96 97 98 99 9a 9b 9c 9d 9e 9f a0 a1 a2 a3 a4 a5 a6 a7
G 9 1 0 b0 b1 b2 b3 b4 b5 b6 b7 b8
G 17 1 0 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf d0
G 31 1 0 e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
         f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe
G 26 3 0 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
         b0 b1 b2 b3 b4 b5 b6 b7 b8 b9

//--- project.f
xgmii_pkg.sv
frame_if.sv
xgmii_rx_deframer.sv
frame_fifo.sv
xgmii_tx_framer.sv
xgmii_loopback_core.sv
frame_fifo_properties.sv
tb_xgmii_loopback.sv

//--- Bender.yml
package:
  name: xgmii_loopback

sources:
  - xgmii_pkg.sv
  - frame_if.sv
  - xgmii_rx_deframer.sv
  - frame_fifo.sv
  - xgmii_tx_framer.sv
  - xgmii_loopback_core.sv
  - target: test
    files:
      - frame_fifo_properties.sv
      - tb_xgmii_loopback.sv
